// ==== switch_pkg.sv ====
`default_nettype none

package switch_pkg;

    localparam int N_PORTS = 4;
    localparam int N_PRIOR = 4;             // Higher value is served first.
    localparam int DATA_W = 16;
    localparam int PAGE_WORDS = 8;
    localparam int N_PAGES = 64;
    localparam int MAX_PKT_PAGES = 4;       // Up to 32 words per packet.
    localparam int ALMOST_FULL_PAGES = 8;

    // Header field positions in the first word.
    localparam int HDR_DEST_LSB = 0;
    localparam int HDR_PRIOR_LSB = 2;

    typedef logic [1:0] port_t;
    typedef logic [1:0] prior_t;
    typedef logic [5:0] page_t;
    typedef logic [2:0] word_idx_t;
    typedef logic [6:0] page_cnt_t;         // Holds 0 to N_PAGES.
    typedef logic [DATA_W-1:0] word_t;

    typedef struct packed {
        logic  vld;
        logic  sop;
        logic  eop;
        word_t data;
    } wr_beat_t;

    typedef struct packed {
        logic  vld;
        logic  sop;
        logic  eop;
        word_t data;
    } rd_beat_t;

    // Request to append a stored packet to its queue.
    typedef struct packed {
        logic   valid;
        port_t  dest;
        prior_t prior;
        page_t  head;
    } join_t;

    typedef enum logic {ING_IDLE, ING_BUSY} ingress_state_e;

    typedef enum logic [1:0] {EGR_IDLE, EGR_FETCH, EGR_STREAM} egress_state_e;

endpackage

`default_nettype wire

// ==== page_free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module page_free_list (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc,
    output switch_pkg::page_t     alloc_page,
    input  logic                  release_en,
    input  switch_pkg::page_t     release_page,
    output switch_pkg::page_cnt_t free_count
);

    logic [switch_pkg::N_PAGES-1:0] free_mask;  // One bit per page, set when free.

    // Lowest free page, scanned from the top so the last hit wins.
    always_comb begin
        alloc_page = '0;
        for (int i = switch_pkg::N_PAGES - 1; i >= 0; i--) begin
            if (free_mask[i])
                alloc_page = switch_pkg::page_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_mask <= '1;
        end else begin
            if (release_en)
                free_mask[release_page] <= 1'b1;
            if (alloc)
                free_mask[alloc_page] <= 1'b0;  // Never the page being released.
        end
    end

    // Net effect of a release and an allocation in the same cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_count <= switch_pkg::page_cnt_t'(switch_pkg::N_PAGES);
        end else begin
            free_count <= free_count
                        + switch_pkg::page_cnt_t'(release_en)
                        - switch_pkg::page_cnt_t'(alloc);
        end
    end

endmodule

`default_nettype wire

// ==== packet_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module packet_buffer (
    input  logic                  clk,
    input  logic                  wr_en,
    input  switch_pkg::page_t     wr_page,
    input  switch_pkg::word_idx_t wr_idx,
    input  switch_pkg::word_t     wr_data,
    input  logic                  wr_end,
    input  logic                  link_en,
    input  switch_pkg::page_t     link_page,
    input  switch_pkg::page_t     link_next,
    input  switch_pkg::page_t     rd_page,
    input  switch_pkg::word_idx_t rd_idx,
    output switch_pkg::word_t     rd_data,
    output logic                  rd_end,
    output switch_pkg::page_t     rd_next
);

    // Each entry is {end, data}.
    logic [switch_pkg::DATA_W:0] word_mem [switch_pkg::N_PAGES * switch_pkg::PAGE_WORDS];
    switch_pkg::page_t next_mem [switch_pkg::N_PAGES];   // Next page of each chained page.

    always_ff @(posedge clk) begin
        if (wr_en)
            word_mem[{wr_page, wr_idx}] <= {wr_end, wr_data};
        if (link_en)
            next_mem[link_page] <= link_next;
    end

    // One cycle of read latency on both memories.
    always_ff @(posedge clk) begin
        {rd_end, rd_data} <= word_mem[{rd_page, rd_idx}];
        rd_next <= next_mem[rd_page];
    end

endmodule

`default_nettype wire

// ==== queue_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module queue_table (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  switch_pkg::join_t                                  join_req,
    input  logic                                               deq,
    input  switch_pkg::port_t                                  deq_port,
    input  switch_pkg::prior_t                                 deq_prior,
    output switch_pkg::page_t                                  deq_head,
    output logic [switch_pkg::N_PORTS*switch_pkg::N_PRIOR-1:0] nonempty
);

    // Queues are indexed by {port, prior}.
    switch_pkg::page_t     head  [switch_pkg::N_PORTS * switch_pkg::N_PRIOR];
    switch_pkg::page_t     tail  [switch_pkg::N_PORTS * switch_pkg::N_PRIOR];
    switch_pkg::page_cnt_t count [switch_pkg::N_PORTS * switch_pkg::N_PRIOR];
    switch_pkg::page_t     chain [switch_pkg::N_PAGES];  // Head page of the next packet.

    logic [$bits(switch_pkg::port_t)+$bits(switch_pkg::prior_t)-1:0] jq;
    logic [$bits(switch_pkg::port_t)+$bits(switch_pkg::prior_t)-1:0] dq;
    logic join_takes_head;

    assign jq = {join_req.dest, join_req.prior};
    assign dq = {deq_port, deq_prior};
    assign deq_head = head[dq];

    // The new packet becomes the head if the queue is, or is about to be, empty.
    assign join_takes_head = (count[jq] == '0)
                          || (deq && dq == jq && count[jq] == switch_pkg::page_cnt_t'(1));

    always_comb begin
        for (int q = 0; q < switch_pkg::N_PORTS * switch_pkg::N_PRIOR; q++)
            nonempty[q] = count[q] != '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < switch_pkg::N_PORTS * switch_pkg::N_PRIOR; q++)
                count[q] <= '0;
        end else begin
            for (int q = 0; q < switch_pkg::N_PORTS * switch_pkg::N_PRIOR; q++) begin
                count[q] <= count[q]
                          + switch_pkg::page_cnt_t'(join_req.valid && jq == q)
                          - switch_pkg::page_cnt_t'(deq && dq == q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq)
            head[dq] <= chain[head[dq]];          // Advance to the next packet.
        if (join_req.valid) begin
            tail[jq] <= join_req.head;
            if (join_takes_head)
                head[jq] <= join_req.head;        // Overrides the advance above.
            else
                chain[tail[jq]] <= join_req.head;
        end
    end

endmodule

`default_nettype wire

// ==== wr_ingress.sv ====
`timescale 1ns/100ps
`default_nettype none

module wr_ingress (
    input  logic                           clk,
    input  logic                           rst_n,
    input  switch_pkg::wr_beat_t           wr_in [switch_pkg::N_PORTS],
    output logic [switch_pkg::N_PORTS-1:0] pause,
    input  switch_pkg::page_cnt_t          free_count,
    output logic                           alloc,
    input  switch_pkg::page_t              alloc_page,
    output logic                           buf_wr_en,
    output switch_pkg::page_t              buf_wr_page,
    output switch_pkg::word_idx_t          buf_wr_idx,
    output switch_pkg::word_t              buf_wr_data,
    output logic                           buf_wr_end,
    output logic                           link_en,
    output switch_pkg::page_t              link_page,
    output switch_pkg::page_t              link_next,
    output switch_pkg::join_t              join_req
);

    switch_pkg::ingress_state_e state;
    switch_pkg::port_t     sel_port;    // Port being written while busy.
    switch_pkg::port_t     sop_port;
    switch_pkg::port_t     cur_port;
    switch_pkg::wr_beat_t  cur;
    switch_pkg::word_idx_t widx;        // Offset of the next word in its page.
    switch_pkg::page_t     cur_page;
    switch_pkg::page_t     head_page;
    switch_pkg::port_t     hdr_dest;
    switch_pkg::prior_t    hdr_prior;
    logic sop_any;
    logic space_ok;
    logic busy;
    logic accept;
    logic page_start;

    assign busy = state == switch_pkg::ING_BUSY;
    assign space_ok = free_count >= switch_pkg::page_cnt_t'(switch_pkg::MAX_PKT_PAGES);

    // Lowest-index port presenting a new packet.
    always_comb begin
        sop_any = 1'b0;
        sop_port = '0;
        for (int p = switch_pkg::N_PORTS - 1; p >= 0; p--) begin
            if (wr_in[p].vld && wr_in[p].sop) begin
                sop_any = 1'b1;
                sop_port = switch_pkg::port_t'(p);
            end
        end
    end

    always_comb begin
        pause = '1;
        if (busy)
            pause[sel_port] = 1'b0;
        else if (space_ok && sop_any)
            pause[sop_port] = 1'b0;
        else if (space_ok)
            pause = '0;                         // Nobody waiting, all open.
    end

    assign cur_port = busy ? sel_port : sop_port;
    assign cur = wr_in[cur_port];
    assign accept = cur.vld && !pause[cur_port] && (busy || cur.sop);
    assign page_start = widx == '0;

    assign alloc = accept && page_start;
    assign buf_wr_en = accept;
    assign buf_wr_page = page_start ? alloc_page : cur_page;
    assign buf_wr_idx = widx;
    assign buf_wr_data = cur.data;
    assign buf_wr_end = cur.eop;
    assign link_en = alloc && busy;         // Crossing into a further page.
    assign link_page = cur_page;
    assign link_next = alloc_page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= switch_pkg::ING_IDLE;
            sel_port <= '0;
            widx <= '0;
            join_req <= '0;
        end else begin
            join_req.valid <= accept && cur.eop;
            join_req.dest <= busy ? hdr_dest : cur.data[switch_pkg::HDR_DEST_LSB +: 2];
            join_req.prior <= busy ? hdr_prior : cur.data[switch_pkg::HDR_PRIOR_LSB +: 2];
            join_req.head <= busy ? head_page : alloc_page;
            if (accept) begin
                widx <= cur.eop ? '0 : widx + 1'b1;
                if (cur.eop) begin
                    state <= switch_pkg::ING_IDLE;
                end else if (!busy) begin
                    state <= switch_pkg::ING_BUSY;
                    sel_port <= sop_port;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            cur_page <= alloc_page;
        if (accept && !busy) begin              // Header word.
            head_page <= alloc_page;
            hdr_dest <= cur.data[switch_pkg::HDR_DEST_LSB +: 2];
            hdr_prior <= cur.data[switch_pkg::HDR_PRIOR_LSB +: 2];
        end
    end

endmodule

`default_nettype wire

// ==== rd_egress.sv ====
`timescale 1ns/100ps
`default_nettype none

module rd_egress (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic [switch_pkg::N_PORTS-1:0]                     ready,
    input  logic [switch_pkg::N_PORTS*switch_pkg::N_PRIOR-1:0] nonempty,
    output logic                                               deq,
    output switch_pkg::port_t                                  deq_port,
    output switch_pkg::prior_t                                 deq_prior,
    input  switch_pkg::page_t                                  deq_head,
    output switch_pkg::page_t                                  buf_rd_page,
    output switch_pkg::word_idx_t                              buf_rd_idx,
    input  switch_pkg::word_t                                  buf_rd_data,
    input  logic                                               buf_rd_end,
    input  switch_pkg::page_t                                  buf_rd_next,
    output logic                                               release_en,
    output switch_pkg::page_t                                  release_page,
    output switch_pkg::rd_beat_t                               rd_out [switch_pkg::N_PORTS]
);

    switch_pkg::egress_state_e state;
    switch_pkg::port_t     rr_ptr;      // First port to look at next time.
    switch_pkg::port_t     out_port;
    switch_pkg::port_t     pick_port;
    switch_pkg::prior_t    pick_prior;
    switch_pkg::page_t     rd_pg;
    switch_pkg::page_t     out_pg;      // Page of the word on the output.
    switch_pkg::word_idx_t rd_ix;
    switch_pkg::word_idx_t out_ix;
    logic [switch_pkg::N_PORTS-1:0] eligible;
    logic found;
    logic follow;                       // Last read was the end of a page.
    logic first;

    always_comb begin
        for (int p = 0; p < switch_pkg::N_PORTS; p++)
            eligible[p] = ready[p] && |nonempty[p*switch_pkg::N_PRIOR +: switch_pkg::N_PRIOR];
    end

    // Round robin from rr_ptr, then highest priority of that port.
    always_comb begin
        found = 1'b0;
        pick_port = rr_ptr;
        for (int i = 0; i < switch_pkg::N_PORTS; i++) begin
            if (!found && eligible[rr_ptr + switch_pkg::port_t'(i)]) begin
                found = 1'b1;
                pick_port = rr_ptr + switch_pkg::port_t'(i);
            end
        end
        pick_prior = '0;
        for (int j = 0; j < switch_pkg::N_PRIOR; j++) begin
            if (nonempty[pick_port*switch_pkg::N_PRIOR + j])
                pick_prior = switch_pkg::prior_t'(j);
        end
    end

    assign deq = state == switch_pkg::EGR_IDLE && found;
    assign deq_port = pick_port;
    assign deq_prior = pick_prior;

    assign buf_rd_page = follow ? buf_rd_next : rd_pg;
    assign buf_rd_idx = rd_ix;

    assign release_en = state == switch_pkg::EGR_STREAM && (out_ix == '1 || buf_rd_end);
    assign release_page = out_pg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= switch_pkg::EGR_IDLE;
            rr_ptr <= '0;
            out_port <= '0;
            first <= 1'b0;
        end else begin
            first <= state == switch_pkg::EGR_FETCH;
            case (state)
                switch_pkg::EGR_IDLE: begin
                    if (found) begin
                        state <= switch_pkg::EGR_FETCH;
                        out_port <= pick_port;
                        rr_ptr <= pick_port + 1'b1;
                    end
                end
                switch_pkg::EGR_FETCH: state <= switch_pkg::EGR_STREAM;
                default: begin
                    if (buf_rd_end)
                        state <= switch_pkg::EGR_IDLE;
                end
            endcase
        end
    end

    // Read address runs one cycle ahead of the output word.
    always_ff @(posedge clk) begin
        if (deq) begin
            rd_pg <= deq_head;
            rd_ix <= '0;
            follow <= 1'b0;
        end else if (state != switch_pkg::EGR_IDLE) begin
            rd_pg <= buf_rd_page;
            rd_ix <= rd_ix + 1'b1;
            follow <= rd_ix == '1;
            out_pg <= buf_rd_page;
            out_ix <= rd_ix;
        end
    end

    always_comb begin
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            rd_out[p].vld = state == switch_pkg::EGR_STREAM && out_port == p;
            rd_out[p].sop = rd_out[p].vld && first;
            rd_out[p].eop = rd_out[p].vld && buf_rd_end;
            rd_out[p].data = rd_out[p].vld ? buf_rd_data : '0;
        end
    end

endmodule

`default_nettype wire

// ==== switch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module switch_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  switch_pkg::wr_beat_t           wr_in [switch_pkg::N_PORTS],
    output logic [switch_pkg::N_PORTS-1:0] pause,
    input  logic [switch_pkg::N_PORTS-1:0] ready,
    output switch_pkg::rd_beat_t           rd_out [switch_pkg::N_PORTS],
    output logic                           full,
    output logic                           almost_full
);

    switch_pkg::page_cnt_t free_count;
    switch_pkg::page_t     alloc_page;
    switch_pkg::page_t     release_page;
    switch_pkg::page_t     buf_wr_page;
    switch_pkg::page_t     link_page;
    switch_pkg::page_t     link_next;
    switch_pkg::page_t     buf_rd_page;
    switch_pkg::page_t     buf_rd_next;
    switch_pkg::page_t     deq_head;
    switch_pkg::word_idx_t buf_wr_idx;
    switch_pkg::word_idx_t buf_rd_idx;
    switch_pkg::word_t     buf_wr_data;
    switch_pkg::word_t     buf_rd_data;
    switch_pkg::join_t     join_req;
    switch_pkg::port_t     deq_port;
    switch_pkg::prior_t    deq_prior;
    logic [switch_pkg::N_PORTS*switch_pkg::N_PRIOR-1:0] nonempty;
    logic alloc;
    logic release_en;
    logic buf_wr_en;
    logic buf_wr_end;
    logic link_en;
    logic buf_rd_end;
    logic deq;

    page_free_list i_free_list (
        .clk, .rst_n, .alloc, .alloc_page, .release_en, .release_page, .free_count
    );

    packet_buffer i_buffer (
        .clk, .wr_en(buf_wr_en), .wr_page(buf_wr_page), .wr_idx(buf_wr_idx),
        .wr_data(buf_wr_data), .wr_end(buf_wr_end), .link_en, .link_page, .link_next,
        .rd_page(buf_rd_page), .rd_idx(buf_rd_idx), .rd_data(buf_rd_data),
        .rd_end(buf_rd_end), .rd_next(buf_rd_next)
    );

    queue_table i_queues (
        .clk, .rst_n, .join_req, .deq, .deq_port, .deq_prior, .deq_head, .nonempty
    );

    wr_ingress i_ingress (
        .clk, .rst_n, .wr_in, .pause, .free_count, .alloc, .alloc_page,
        .buf_wr_en, .buf_wr_page, .buf_wr_idx, .buf_wr_data, .buf_wr_end,
        .link_en, .link_page, .link_next, .join_req
    );

    rd_egress i_egress (
        .clk, .rst_n, .ready, .nonempty, .deq, .deq_port, .deq_prior, .deq_head,
        .buf_rd_page, .buf_rd_idx, .buf_rd_data, .buf_rd_end, .buf_rd_next,
        .release_en, .release_page, .rd_out
    );

    // Fill flags, one cycle behind the free count.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            full <= free_count == '0;
            almost_full <= free_count < switch_pkg::page_cnt_t'(switch_pkg::ALMOST_FULL_PAGES);
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD_NS = 10;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a rising edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_switch.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_switch;

    localparam int MAX_PKTS = 64;
    localparam int MAX_WORDS = 32;

    logic clk;
    logic rst_n;
    switch_pkg::wr_beat_t wr_in [switch_pkg::N_PORTS];
    switch_pkg::rd_beat_t rd_out [switch_pkg::N_PORTS];
    logic [switch_pkg::N_PORTS-1:0] pause;
    logic [switch_pkg::N_PORTS-1:0] ready;
    logic full;
    logic almost_full;

    int op_q [$];                           // Command letters, in file order.
    int arg_q [$];                          // Five arguments per command.
    switch_pkg::word_t pkt_data [MAX_PKTS*MAX_WORDS];
    int pkt_len [MAX_PKTS];
    int pkt_dst [MAX_PKTS];
    int pkt_pri [MAX_PKTS];
    int join_cyc [MAX_PKTS];
    int src_q [switch_pkg::N_PORTS][$];     // Packets waiting at each source.
    int join_q [switch_pkg::N_PORTS][$];    // Joined packets per output, in join order.
    int cur_id [switch_pkg::N_PORTS];
    int cur_w [switch_pkg::N_PORTS];
    int out_id [switch_pkg::N_PORTS];
    int out_w [switch_pkg::N_PORTS];
    logic [switch_pkg::N_PORTS-1:0] acc;
    logic [switch_pkg::N_PORTS-1:0] ready_mask;
    logic [switch_pkg::N_PORTS-1:0] ready_d1;
    logic [switch_pkg::N_PORTS-1:0] ready_d2;
    logic sending;
    logic in_busy;
    int in_port;
    int cyc;
    int n_created;
    int n_delivered;
    int limit_cycles;
    int seed;

    tb_clock_gen i_clock (.clk, .rst_n);

    switch_top i_dut (
        .clk, .rst_n, .wr_in, .pause, .ready, .rd_out, .full, .almost_full
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic read_vectors();
        int fd;
        int n;
        int total;
        int npkt;
        int a [5];
        string line;
        total = 0;
        npkt = 0;
        fd = $fopen("switch_vectors.txt", "r");
        if (fd == 0)
            stop_run("cannot open switch_vectors.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.getc(0) == "#" || line.getc(0) < "A")
                continue;
            a = '{0, 0, 0, 0, 1};               // Repeat count defaults to one.
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                        a[0], a[1], a[2], a[3], a[4]);
            op_q.push_back(int'(line.getc(0)));
            for (int i = 0; i < 5; i++)
                arg_q.push_back(a[i]);
            if (line.getc(0) == "P") begin
                total += a[3] * a[4];
                npkt += a[4];
            end
        end
        $fclose(fd);
        limit_cycles = 1000 + 4 * total + 16 * npkt + 8 * op_q.size();
    endtask

    task automatic make_packet(input int src, input int dst, input int pri, input int len);
        int id;
        switch_pkg::word_t hdr;
        id = n_created;
        if (len < 1 || len > MAX_WORDS || id >= MAX_PKTS || src > 3 || dst > 3 || pri > 3)
            stop_run("a packet in the vectors is out of range");
        else begin
            n_created++;
            pkt_len[id] = len;
            pkt_dst[id] = dst;
            pkt_pri[id] = pri;
            hdr = switch_pkg::word_t'($random(seed));
            hdr[switch_pkg::HDR_DEST_LSB +: 2] = dst[1:0];
            hdr[switch_pkg::HDR_PRIOR_LSB +: 2] = pri[1:0];
            pkt_data[id*MAX_WORDS] = hdr;
            for (int w = 1; w < len; w++)
                pkt_data[id*MAX_WORDS + w] = switch_pkg::word_t'($random(seed));
            src_q[src].push_back(id);
        end
    endtask

    // Visible in the queues two cycles after eop, chosen two cycles before sop.
    function automatic int pick_expected(input int d);
        for (int pr = switch_pkg::N_PRIOR - 1; pr >= 0; pr--) begin
            for (int i = 0; i < join_q[d].size(); i++) begin
                if (pkt_pri[join_q[d][i]] == pr && join_cyc[join_q[d][i]] + 4 <= cyc)
                    return i;
            end
        end
        return -1;
    endfunction

    function automatic logic sources_idle();
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            if (cur_id[p] >= 0 || src_q[p].size() > 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic take_word(input int p);
        int id;
        logic lower;
        id = cur_id[p];
        lower = 1'b0;
        for (int q = 0; q < p; q++)
            lower = lower || (wr_in[q].vld && wr_in[q].sop);
        if (wr_in[p].sop && (in_busy || lower))
            stop_run($sformatf("packet on input port %0d was accepted out of turn", p));
        else if (!wr_in[p].sop && (!in_busy || in_port != p))
            stop_run($sformatf("input port %0d had a word accepted outside its packet", p));
        else begin
            in_busy = !wr_in[p].eop;
            in_port = p;
            if (wr_in[p].eop) begin
                join_cyc[id] = cyc;
                join_q[pkt_dst[id]].push_back(id);
            end
        end
    endtask

    task automatic see_output(input int d);
        int i;
        i = rd_out[d].sop ? pick_expected(d) : 0;
        if (rd_out[d].sop && (out_id[d] >= 0 || i < 0))
            stop_run($sformatf("output port %0d started a packet that was not expected", d));
        else if (!rd_out[d].sop && out_id[d] < 0)
            stop_run($sformatf("output port %0d sent a word outside of a packet", d));
        else begin
            if (rd_out[d].sop) begin
                check_value($sformatf("ready[%0d] at packet choice", d), ready_d2[d], 1);
                out_id[d] = join_q[d][i];
                join_q[d].delete(i);
                out_w[d] = 0;
            end
            check_value($sformatf("rd_out[%0d].data", d), rd_out[d].data,
                        pkt_data[out_id[d]*MAX_WORDS + out_w[d]]);
            check_value($sformatf("rd_out[%0d].eop", d), rd_out[d].eop,
                        out_w[d] == pkt_len[out_id[d]] - 1);
            if (rd_out[d].eop) begin
                out_id[d] = -1;
                n_delivered++;
            end else begin
                out_w[d]++;
            end
        end
    endtask

    task automatic send_all();
        sending = 1'b1;
        @(negedge clk);
        while (!sources_idle())
            @(negedge clk);
        sending = 1'b0;
    endtask

    // Flags take two cycles to follow the free count.
    task automatic check_quiet(input int af, input int fl, input int pz);
        repeat (3) @(negedge clk);
        check_value("almost_full", almost_full, af);
        check_value("full", full, fl);
        check_value("pause", pause, pz);
        for (int p = 0; p < switch_pkg::N_PORTS; p++)
            check_value($sformatf("rd_out[%0d].vld", p), rd_out[p].vld, 0);
    endtask

    // Source lanes, each word held until accepted.
    always @(posedge clk) begin : drive_sources
        switch_pkg::wr_beat_t beat;
        cyc = cyc + 1;
        ready <= ready_mask;
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            if (acc[p]) begin
                cur_w[p] = cur_w[p] + 1;
                if (cur_w[p] == pkt_len[cur_id[p]])
                    cur_id[p] = -1;
            end
            if (cur_id[p] < 0 && sending && src_q[p].size() > 0) begin
                cur_id[p] = src_q[p].pop_front();
                cur_w[p] = 0;
            end
            beat = '0;
            if (cur_id[p] >= 0) begin
                beat.vld = 1'b1;
                beat.sop = cur_w[p] == 0;
                beat.eop = cur_w[p] == pkt_len[cur_id[p]] - 1;
                beat.data = pkt_data[cur_id[p]*MAX_WORDS + cur_w[p]];
            end
            wr_in[p] <= beat;
        end
    end

    always @(negedge clk) begin : watch_ports
        logic [switch_pkg::N_PORTS-1:0] open_mask;
        int nvld;
        if (rst_n) begin
            open_mask = '1;
            if (in_busy) begin
                open_mask[in_port] = 1'b0;      // Only the port being written.
                check_value("pause", pause, open_mask);
            end
            nvld = 0;
            for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
                acc[p] = wr_in[p].vld && !pause[p];
                if (acc[p])
                    take_word(p);
                if (rd_out[p].vld) begin
                    nvld++;
                    see_output(p);
                end else if (out_id[p] >= 0) begin
                    stop_run($sformatf("output port %0d has a gap inside a packet", p));
                end
            end
            if (nvld > 1)
                stop_run("more than one output port is sending at once");
            ready_d2 = ready_d1;
            ready_d1 = ready;
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        stop_run("timeout, the switch stopped making progress");
    end

    initial begin : run_vectors
        int op;
        int a [5];
        seed = 32'hd588;
        cyc = 0;
        n_created = 0;
        n_delivered = 0;
        limit_cycles = 0;
        sending = 1'b0;
        in_busy = 1'b0;
        in_port = 0;
        acc = '0;
        ready_mask = '0;
        ready_d1 = '0;
        ready_d2 = '0;
        ready <= '0;
        for (int p = 0; p < switch_pkg::N_PORTS; p++) begin
            cur_id[p] = -1;
            out_id[p] = -1;
            cur_w[p] = 0;
            out_w[p] = 0;
            wr_in[p] <= '0;
        end
        read_vectors();
        wait (rst_n === 1'b1);
        @(negedge clk);
        while (op_q.size() > 0) begin
            op = op_q.pop_front();
            for (int i = 0; i < 5; i++)
                a[i] = arg_q.pop_front();
            case (op)
                "R": ready_mask = a[0][switch_pkg::N_PORTS-1:0];
                "P": begin
                    for (int k = 0; k < a[4]; k++)
                        make_packet(a[0], a[1], a[2], a[3]);
                end
                "S": send_all();
                "D": begin
                    while (n_delivered != n_created)
                        @(negedge clk);
                end
                "E": check_quiet(a[0], a[1], a[2]);
                default: stop_run("unknown command in the vectors");
            endcase
        end
        repeat (4) @(negedge clk);
        if (n_delivered == n_created && !in_busy) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_run("the run ended with packets still inside the switch");
        end
    end

endmodule

`default_nettype wire

// ==== switch_vectors.txt ====
# Fields in hex. R mask: ready | P src dst pri len [count]: queue packets at a source
# S: send queued packets | D: wait for delivery | E af full pause: check a quiet switch
E 0 0 0
R f
P 0 2 1 0c
S
D
R 0
P 0 1 0 05
P 0 1 2 0a
P 2 1 3 03
P 3 1 0 01
P 0 1 3 12
P 2 1 2 08
S
R 2
D
R f
P 0 3 2 10
P 1 3 2 09
S
D
P 0 0 1 20
P 1 1 2 07
P 2 2 3 0d
P 3 3 0 11
P 3 0 2 02
P 2 1 1 19
S
D
R 7
P 1 3 1 20 e
S
E 0 0 0
P 2 3 2 20
S
E 1 0 0
P 0 3 3 20
S
E 1 1 f
R f
D
E 0 0 0

// ==== verilog.f ====
switch_pkg.sv
page_free_list.sv
packet_buffer.sv
queue_table.sv
wr_ingress.sv
rd_egress.sv
switch_top.sv
tb_clock_gen.sv
tb_switch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_switch
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
